// ==== fb_pkg.sv ====
package fb_pkg;

  // 32 x 32 screen
  localparam int fb_h_width = 5;
  localparam int fb_v_width = 5;
  localparam int fb_pixel_width = 8;

  // one pixel write of 18 bits
  typedef struct packed {
    logic [fb_h_width-1:0]     x;
    logic [fb_v_width-1:0]     y;
    logic [fb_pixel_width-1:0] pixel;
  } fb_wr_t;

endpackage

// ==== gfx_pkg.sv ====
package gfx_pkg;
  import fb_pkg::*;

  // two opposite corners in any order plus a fill color in 28 bits
  typedef struct packed {
    logic [fb_h_width-1:0]     x0;
    logic [fb_v_width-1:0]     y0;
    logic [fb_h_width-1:0]     x1;
    logic [fb_v_width-1:0]     y1;
    logic [fb_pixel_width-1:0] color;
  } rect_cmd_t;

  // filler and outliner
  localparam int gfx_n_engines = 2;

endpackage

// ==== gfx_rect_fill.sv ====
module gfx_rect_fill (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  output logic               done,
  input  gfx_pkg::rect_cmd_t cmd,
  output logic               pix_valid,
  output fb_pkg::fb_wr_t     pix,
  input  logic               pix_ready
);
  import fb_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_fill,
    st_done
  } state_t;

  state_t state;

  logic [fb_h_width-1:0]     x_lo;
  logic [fb_h_width-1:0]     x_hi;
  logic [fb_v_width-1:0]     y_lo;
  logic [fb_v_width-1:0]     y_hi;

  logic [fb_h_width-1:0]     x_min;
  logic [fb_h_width-1:0]     x_max;
  logic [fb_v_width-1:0]     y_min;
  logic [fb_v_width-1:0]     y_max;
  logic [fb_h_width-1:0]     cur_x;
  logic [fb_v_width-1:0]     cur_y;
  logic [fb_pixel_width-1:0] color;

  logic                      advance;

  // corners may come in either order
  assign x_lo = (cmd.x0 <= cmd.x1) ? cmd.x0 : cmd.x1;
  assign x_hi = (cmd.x0 <= cmd.x1) ? cmd.x1 : cmd.x0;
  assign y_lo = (cmd.y0 <= cmd.y1) ? cmd.y0 : cmd.y1;
  assign y_hi = (cmd.y0 <= cmd.y1) ? cmd.y1 : cmd.y0;

  // output slot is free or is being taken this cycle
  assign advance = !pix_valid || pix_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      pix_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      if (pix_valid && pix_ready) begin
        pix_valid <= 1'b0;
      end

      case (state)
        st_idle: begin
          if (start) begin
            state <= st_setup;
          end
        end

        st_setup: begin
          x_min <= x_lo;
          x_max <= x_hi;
          y_min <= y_lo;
          y_max <= y_hi;
          cur_x <= x_lo;
          cur_y <= y_lo;
          color <= cmd.color;
          state <= st_fill;
        end

        st_fill: begin
          if (advance) begin
            pix_valid <= 1'b1;
            pix.x     <= cur_x;
            pix.y     <= cur_y;
            pix.pixel <= color;
            if (cur_x != x_max) begin
              cur_x <= cur_x + 1'b1;
            end else begin
              cur_x <= x_min;
              if (cur_y != y_max) begin
                cur_y <= cur_y + 1'b1;
              end else begin
                state <= st_done;
              end
            end
          end
        end

        st_done: begin
          // last pixel is still in the output slot until it transfers
          if (done) begin
            if (!start) begin
              done  <= 1'b0;
              state <= st_idle;
            end
          end else if (pix_valid && pix_ready) begin
            done <= 1'b1;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== gfx_rect_outline.sv ====
module gfx_rect_outline (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  output logic               done,
  input  gfx_pkg::rect_cmd_t cmd,
  output logic               pix_valid,
  output fb_pkg::fb_wr_t     pix,
  input  logic               pix_ready
);
  import fb_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_setup,
    st_top,
    st_bottom,
    st_side,
    st_done
  } state_t;

  state_t state;

  logic [fb_h_width-1:0]     x_min;
  logic [fb_h_width-1:0]     x_max;
  logic [fb_v_width-1:0]     y_min;
  logic [fb_v_width-1:0]     y_max;
  logic [fb_h_width-1:0]     cur_x;
  logic [fb_v_width-1:0]     cur_y;
  logic [fb_pixel_width-1:0] color;

  logic                      walking;
  logic                      advance;

  assign walking = (state == st_top) || (state == st_bottom) || (state == st_side);
  assign advance = walking && (!pix_valid || pix_ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      pix_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      if (pix_valid && pix_ready) begin
        pix_valid <= 1'b0;
      end

      // every phase emits the current position
      if (advance) begin
        pix_valid <= 1'b1;
        pix.x     <= cur_x;
        pix.y     <= cur_y;
        pix.pixel <= color;
      end

      case (state)
        st_idle: begin
          if (start) begin
            state <= st_setup;
          end
        end

        st_setup: begin
          x_min <= (cmd.x0 <= cmd.x1) ? cmd.x0 : cmd.x1;
          x_max <= (cmd.x0 <= cmd.x1) ? cmd.x1 : cmd.x0;
          y_min <= (cmd.y0 <= cmd.y1) ? cmd.y0 : cmd.y1;
          y_max <= (cmd.y0 <= cmd.y1) ? cmd.y1 : cmd.y0;
          cur_x <= (cmd.x0 <= cmd.x1) ? cmd.x0 : cmd.x1;
          cur_y <= (cmd.y0 <= cmd.y1) ? cmd.y0 : cmd.y1;
          color <= cmd.color;
          state <= st_top;
        end

        st_top: begin
          if (advance) begin
            if (cur_x != x_max) begin
              cur_x <= cur_x + 1'b1;
            end else if (y_max == y_min) begin
              // a 1-tall box has no bottom row
              state <= st_done;
            end else begin
              cur_x <= x_min;
              cur_y <= y_max;
              state <= st_bottom;
            end
          end
        end

        st_bottom: begin
          if (advance) begin
            if (cur_x != x_max) begin
              cur_x <= cur_x + 1'b1;
            end else if (y_max == y_min + 1'b1) begin
              state <= st_done;
            end else begin
              cur_x <= x_min;
              cur_y <= y_min + 1'b1;
              state <= st_side;
            end
          end
        end

        st_side: begin
          // left then right; a 1-wide box skips straight to the next row
          if (advance) begin
            if (cur_x != x_max) begin
              cur_x <= x_max;
            end else if (cur_y == y_max - 1'b1) begin
              state <= st_done;
            end else begin
              cur_x <= x_min;
              cur_y <= cur_y + 1'b1;
            end
          end
        end

        st_done: begin
          if (done) begin
            if (!start) begin
              done  <= 1'b0;
              state <= st_idle;
            end
          end else if (pix_valid && pix_ready) begin
            done <= 1'b1;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== gfx_write_arbiter.sv ====
module gfx_write_arbiter #(
  parameter int  n_req     = 2,
  parameter type payload_t = logic
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [n_req-1:0] req_valid,
  input  payload_t         req_payload [n_req],
  output logic [n_req-1:0] req_ready,
  output logic             out_valid,
  output payload_t         out_payload
);

  localparam int ptr_w = (n_req > 1) ? $clog2(n_req) : 1;

  logic [ptr_w-1:0] ptr;
  logic [ptr_w-1:0] winner;
  logic             any_valid;

  // first valid requester at or after the pointer, wrapping around
  always_comb begin
    int idx;
    any_valid = 1'b0;
    winner    = ptr;
    for (int i = 0; i < n_req; i++) begin
      idx = (int'(ptr) + i) % n_req;
      if (!any_valid && req_valid[idx]) begin
        any_valid = 1'b1;
        winner    = ptr_w'(idx);
      end
    end
  end

  always_comb begin
    req_ready         = '0;
    req_ready[winner] = any_valid;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr       <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= any_valid;
      // winner drops to lowest priority
      if (any_valid) begin
        ptr <= (int'(winner) == n_req - 1) ? '0 : winner + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (any_valid) begin
      out_payload <= req_payload[winner];
    end
  end

endmodule

// ==== gfx_framebuffer.sv ====
module gfx_framebuffer (
  input  logic                              clk,
  input  logic                              wr_valid,
  input  fb_pkg::fb_wr_t                    wr,
  input  logic [fb_pkg::fb_h_width-1:0]     rd_x,
  input  logic [fb_pkg::fb_v_width-1:0]     rd_y,
  output logic [fb_pkg::fb_pixel_width-1:0] rd_pixel
);
  import fb_pkg::*;

  localparam int addr_w = fb_h_width + fb_v_width;

  // row-major, y in the upper address bits
  logic [fb_pixel_width-1:0] mem [1 << addr_w];

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[{wr.y, wr.x}] <= wr.pixel;
    end
  end

  // read of an address written in the same cycle sees the old pixel
  always_ff @(posedge clk) begin
    rd_pixel <= mem[{rd_y, rd_x}];
  end

endmodule

// ==== gfx_top.sv ====
module gfx_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [gfx_pkg::gfx_n_engines-1:0] start,
  output logic [gfx_pkg::gfx_n_engines-1:0] done,
  input  gfx_pkg::rect_cmd_t                cmd [gfx_pkg::gfx_n_engines],
  input  logic [fb_pkg::fb_h_width-1:0]     rd_x,
  input  logic [fb_pkg::fb_v_width-1:0]     rd_y,
  output logic [fb_pkg::fb_pixel_width-1:0] rd_pixel
);
  import fb_pkg::*;
  import gfx_pkg::*;

  logic [gfx_n_engines-1:0] pix_valid;
  logic [gfx_n_engines-1:0] pix_ready;
  fb_wr_t                   pix [gfx_n_engines];

  logic                     fb_valid;
  fb_wr_t                   fb_wr;

  gfx_rect_fill gfx_rect_fill_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start[0]),
    .done      (done[0]),
    .cmd       (cmd[0]),
    .pix_valid (pix_valid[0]),
    .pix       (pix[0]),
    .pix_ready (pix_ready[0])
  );

  gfx_rect_outline gfx_rect_outline_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start[1]),
    .done      (done[1]),
    .cmd       (cmd[1]),
    .pix_valid (pix_valid[1]),
    .pix       (pix[1]),
    .pix_ready (pix_ready[1])
  );

  gfx_write_arbiter #(
    .n_req     (gfx_n_engines),
    .payload_t (fb_wr_t)
  ) gfx_write_arbiter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (pix_valid),
    .req_payload (pix),
    .req_ready   (pix_ready),
    .out_valid   (fb_valid),
    .out_payload (fb_wr)
  );

  gfx_framebuffer gfx_framebuffer_inst (
    .clk      (clk),
    .wr_valid (fb_valid),
    .wr       (fb_wr),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_pixel (rd_pixel)
  );

endmodule

// ==== gfx_properties.sv ====
module gfx_properties #(
  parameter int n_ready   = 1,
  parameter int payload_w = 18
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 valid,
  input logic [n_ready-1:0]   ready,
  input logic [payload_w-1:0] payload,
  input logic                 done
);

  if (n_ready > 1) begin : grant_checks
    // the arbiter serves one stream at a time
    ready_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ready))
      else $error("more than one ready in the same cycle");
  end else begin : stream_checks
    // a stalled transfer keeps its payload
    payload_held: assert property (@(posedge clk) disable iff (!rst_n)
      valid && !ready[0] |=> $stable(payload))
      else $error("payload changed while valid and not ready");
  end

  reset_quiet: assert property (@(posedge clk) !rst_n |=> !valid && !done)
    else $error("valid or done high in the cycle after reset");

endmodule

bind gfx_rect_fill gfx_properties #(
  .n_ready   (1),
  .payload_w ($bits(fb_pkg::fb_wr_t))
) fill_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .valid   (pix_valid),
  .ready   (pix_ready),
  .payload (pix),
  .done    (done)
);

bind gfx_rect_outline gfx_properties #(
  .n_ready   (1),
  .payload_w ($bits(fb_pkg::fb_wr_t))
) outline_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .valid   (pix_valid),
  .ready   (pix_ready),
  .payload (pix),
  .done    (done)
);

// the arbiter has no done of its own
bind gfx_write_arbiter gfx_properties #(
  .n_ready   (gfx_pkg::gfx_n_engines),
  .payload_w ($bits(fb_pkg::fb_wr_t))
) arbiter_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .valid   (out_valid),
  .ready   (req_ready),
  .payload (out_payload),
  .done    (1'b0)
);

// ==== gfx_tb.sv ====
module gfx_tb;
  import fb_pkg::*;
  import gfx_pkg::*;

  localparam int addr_w      = fb_h_width + fb_v_width;
  localparam int h_px        = 1 << fb_h_width;
  localparam int screen_px   = 1 << addr_w;
  localparam int n_cmds      = 31;
  localparam int n_sweeps    = 5;
  localparam int cycle_limit = (n_cmds * screen_px + n_sweeps * (screen_px + 2)) * 2 + 2000;

  logic                      clk;
  logic                      rst_n;
  logic [gfx_n_engines-1:0]  start;
  logic [gfx_n_engines-1:0]  done;
  rect_cmd_t                 cmd [gfx_n_engines];
  logic [fb_h_width-1:0]     rd_x;
  logic [fb_v_width-1:0]     rd_y;
  logic [fb_pixel_width-1:0] rd_pixel;

  logic [fb_pixel_width-1:0] shadow [screen_px];
  logic                      rd_active;
  logic                      chk_valid = 1'b0;
  logic [addr_w-1:0]         chk_addr;
  int                        checks = 0;
  int                        pix_errors = 0;
  int                        ctrl_errors = 0;
  int                        cycles = 0;

  gfx_top gfx_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .done     (done),
    .cmd      (cmd),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_pixel (rd_pixel)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic rect_cmd_t make_cmd(int x0, int y0, int x1, int y1, int color);
    rect_cmd_t c;
    c.x0    = fb_h_width'(x0);
    c.y0    = fb_v_width'(y0);
    c.x1    = fb_h_width'(x1);
    c.y1    = fb_v_width'(y1);
    c.color = fb_pixel_width'(color);
    return c;
  endfunction

  // engine 0 fills the box, engine 1 paints only its border
  function automatic void paint_shadow(int engine, rect_cmd_t c);
    int xl;
    int xh;
    int yl;
    int yh;
    xl = (int'(c.x0) < int'(c.x1)) ? int'(c.x0) : int'(c.x1);
    xh = (int'(c.x0) < int'(c.x1)) ? int'(c.x1) : int'(c.x0);
    yl = (int'(c.y0) < int'(c.y1)) ? int'(c.y0) : int'(c.y1);
    yh = (int'(c.y0) < int'(c.y1)) ? int'(c.y1) : int'(c.y0);
    for (int y = yl; y <= yh; y++) begin
      for (int x = xl; x <= xh; x++) begin
        if (engine == 0 || x == xl || x == xh || y == yl || y == yh) begin
          shadow[addr_w'(y * h_px + x)] = c.color;
        end
      end
    end
  endfunction

  task automatic run_cmds(input logic [gfx_n_engines-1:0] mask, input rect_cmd_t c0,
                          input rect_cmd_t c1);
    cmd[0] = c0;
    cmd[1] = c1;
    for (int e = 0; e < gfx_n_engines; e++) begin
      if (mask[e]) begin
        paint_shadow(e, cmd[e]);
      end
    end
    start = mask;
    do begin
      @(posedge clk);
      #1;
      assert ((done & gfx_top_inst.pix_valid) == '0) else begin
        $display("engine raised done while its pixel stream was still busy");
        ctrl_errors++;
      end
    end while ((done & mask) != mask);
    repeat (3) begin
      @(posedge clk);
      #1;
      assert ((done & mask) == mask) else begin
        $display("ERROR %0t: done expected %b got %b", $time, mask, done & mask);
        ctrl_errors++;
      end
    end
    start = '0;
    @(posedge clk);
    #1;
    assert ((done & mask) == '0) else begin
      $display("ERROR %0t: done expected %b got %b", $time, 2'b00, done & mask);
      ctrl_errors++;
    end
  endtask

  task automatic sweep_screen();
    rd_active = 1'b1;
    for (int a = 0; a < screen_px; a++) begin
      rd_x = fb_h_width'(a % h_px);
      rd_y = fb_v_width'(a / h_px);
      @(posedge clk);
      #1;
    end
    rd_active = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // rd_pixel is registered, so compare half a cycle after the read edge
  always @(posedge clk) begin
    chk_valid <= rd_active;
    chk_addr  <= {rd_y, rd_x};
  end

  always @(negedge clk) begin
    if (chk_valid) begin
      checks++;
      assert (rd_pixel === shadow[chk_addr]) else begin
        $display("ERROR %0t: rd_pixel at x=%0d y=%0d expected %h got %h", $time,
                 chk_addr[fb_h_width-1:0], chk_addr[addr_w-1:fb_h_width],
                 shadow[chk_addr], rd_pixel);
        pix_errors++;
      end
    end
  end

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [gfx_n_engines-1:0] pick;
    rect_cmd_t                rc;
    void'($urandom(35));
    rst_n     = 1'b0;
    start     = '0;
    cmd[0]    = make_cmd(0, 0, 0, 0, 0);
    cmd[1]    = make_cmd(0, 0, 0, 0, 0);
    rd_x      = '0;
    rd_y      = '0;
    rd_active = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    run_cmds(2'b01, make_cmd(0, 0, h_px - 1, h_px - 1, 8'h00), cmd[1]);

    // reversed corners
    run_cmds(2'b01, make_cmd(20, 17, 3, 5, 8'h5a), cmd[1]);
    sweep_screen();

    // plain box then the 2-tall, 1-wide, 1-tall and single-pixel cases
    run_cmds(2'b10, cmd[0], make_cmd(28, 10, 25, 3, 8'h81));
    run_cmds(2'b10, cmd[0], make_cmd(14, 12, 18, 13, 8'h3c));
    run_cmds(2'b10, cmd[0], make_cmd(7, 28, 7, 20, 8'hc3));
    run_cmds(2'b10, cmd[0], make_cmd(10, 30, 22, 30, 8'h99));
    run_cmds(2'b10, cmd[0], make_cmd(30, 1, 30, 1, 8'he7));
    sweep_screen();

    // both engines at once on disjoint boxes
    run_cmds(2'b11, make_cmd(0, 0, 9, 9, 8'h11), make_cmd(15, 20, 26, 29, 8'h22));
    sweep_screen();

    run_cmds(2'b01, make_cmd(4, 4, 12, 6, 8'h44), cmd[1]);
    run_cmds(2'b01, make_cmd(6, 2, 8, 15, 8'h66), cmd[1]);
    sweep_screen();

    for (int n = 0; n < 20; n++) begin
      pick = ($urandom % 2 == 0) ? 2'b01 : 2'b10;
      rc   = make_cmd($urandom % h_px, $urandom % h_px, $urandom % h_px,
                      $urandom % h_px, $urandom % 256);
      run_cmds(pick, rc, rc);
    end
    sweep_screen();

    // every sweep compares the whole screen
    assert (checks == n_sweeps * screen_px) else begin
      $display("ERROR %0t: checks expected %0d got %0d", $time, n_sweeps * screen_px,
               checks);
      ctrl_errors++;
    end

    $display("checks %0d, pixel errors %0d, control errors %0d", checks, pix_errors,
             ctrl_errors);
    if (pix_errors == 0 && ctrl_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
fb_pkg.sv
gfx_pkg.sv
gfx_rect_fill.sv
gfx_rect_outline.sv
gfx_write_arbiter.sv
gfx_framebuffer.sv
gfx_top.sv
gfx_properties.sv
gfx_tb.sv

// ==== Makefile ====
obj_dir/Vgfx_tb: src.f $(shell cat src.f)
	verilator --binary --timing --assert -f src.f --top-module gfx_tb -o Vgfx_tb

run: obj_dir/Vgfx_tb
	@out="$$(./obj_dir/Vgfx_tb)"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

.PHONY: run clean
